// File: design/isa_pkg.sv
package isa_pkg;

    // R-type layout, also used for funct3 of the immediate forms
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view;

    typedef union packed {
        r_view r;
        i_view i;
    } inst_word;

    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_MULT
    } fu_kind;

    // Values follow funct3 of the OP and OP-IMM groups
    typedef enum logic [2:0] {
        ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_OR, ALU_AND
    } alu_op;

    typedef enum logic {
        OPB_REG,
        OPB_IMM
    } opb_source;

endpackage

// File: design/issue_pkg.sv
package issue_pkg;

    localparam int PHYS_REG_BITS = 6;
    localparam int NUM_PHYS_REGS = 1 << PHYS_REG_BITS;

    typedef logic [PHYS_REG_BITS-1:0] phys_reg;
    typedef logic [31:0] data_word;

    // One reservation station entry as seen by issue
    typedef struct packed {
        logic               valid;
        phys_reg            source1;
        logic               source1_ready;
        phys_reg            source2;
        logic               source2_ready;
        phys_reg            dest;
        isa_pkg::fu_kind    kind;
        isa_pkg::opb_source opb;
        isa_pkg::inst_word  inst;
    } rs_entry;

    typedef struct packed {
        logic     valid;
        phys_reg  completing_reg;
        data_word result;
    } cdb_broadcast;

    typedef struct packed {
        logic           valid;
        phys_reg        dest;
        isa_pkg::alu_op op;
        data_word       operand_a;
        data_word       operand_b;
    } alu_packet;

    // mult_func is funct3 of the M extension
    typedef struct packed {
        logic       valid;
        phys_reg    dest;
        logic [2:0] mult_func;
        data_word   operand_a;
        data_word   operand_b;
    } mult_packet;

endpackage

// File: design/issue_register.sv
`timescale 1ns/100ps

module issue_register #(
    parameter int NUM_ALU = 2,
    parameter int NUM_MULT = 2,
    parameter int CDB_PORTS = 2
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [issue_pkg::NUM_PHYS_REGS-1:0]    complete_list,
    input  issue_pkg::cdb_broadcast [CDB_PORTS-1:0] cdb,
    issue_slot_if.consumer                         sel_slots,
    issue_slot_if.buffer                           held_slots
);

    // Later ports win if two broadcast the same register
    function automatic issue_pkg::data_word cdb_value(issue_pkg::phys_reg r);
        issue_pkg::data_word value;

        value = '0;
        for (int p = 0; p < CDB_PORTS; p++) begin
            if (cdb[p].valid && cdb[p].completing_reg == r) begin
                value = cdb[p].result;
            end
        end
        return value;
    endfunction

    function automatic logic source_covered(issue_pkg::phys_reg r);
        logic hit;

        hit = complete_list[r];
        for (int p = 0; p < CDB_PORTS; p++) begin
            hit |= cdb[p].valid && cdb[p].completing_reg == r;
        end
        return hit;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            held_slots.alu_valid <= '0;
            held_slots.mult_valid <= '0;
        end else begin
            held_slots.alu_valid <= sel_slots.alu_valid;
            held_slots.mult_valid <= sel_slots.mult_valid;
        end
    end

    // Operand source decided now, register file answers next cycle
    always_ff @(posedge clock) begin
        held_slots.alu_entry <= sel_slots.alu_entry;
        held_slots.mult_entry <= sel_slots.mult_entry;
        held_slots.mult_unit <= sel_slots.mult_unit;
        for (int k = 0; k < NUM_ALU; k++) begin
            held_slots.alu_in_rf[k] <= {complete_list[sel_slots.alu_entry[k].source2],
                                        complete_list[sel_slots.alu_entry[k].source1]};
            held_slots.alu_captured[k] <= {cdb_value(sel_slots.alu_entry[k].source2),
                                           cdb_value(sel_slots.alu_entry[k].source1)};
        end
        for (int k = 0; k < NUM_MULT; k++) begin
            held_slots.mult_in_rf[k] <= {complete_list[sel_slots.mult_entry[k].source2],
                                         complete_list[sel_slots.mult_entry[k].source1]};
            held_slots.mult_captured[k] <= {cdb_value(sel_slots.mult_entry[k].source2),
                                            cdb_value(sel_slots.mult_entry[k].source1)};
        end
    end

    // A ready source that is not complete must be on the cdb this cycle
    for (genvar k = 0; k < NUM_ALU; k++) begin : g_alu_check
        assert property (@(posedge clock) disable iff (reset)
            sel_slots.alu_valid[k] |-> source_covered(sel_slots.alu_entry[k].source1)
                && source_covered(sel_slots.alu_entry[k].source2));
    end

    for (genvar k = 0; k < NUM_MULT; k++) begin : g_mult_check
        assert property (@(posedge clock) disable iff (reset)
            sel_slots.mult_valid[k] |-> source_covered(sel_slots.mult_entry[k].source1)
                && source_covered(sel_slots.mult_entry[k].source2));
    end

endmodule

// File: design/issue_slot_if.sv
`timescale 1ns/100ps

interface issue_slot_if #(
    parameter int NUM_ALU = 2,
    parameter int NUM_MULT = 2
) (
    input logic clock
);
    localparam int UNIT_BITS = (NUM_MULT > 1) ? $clog2(NUM_MULT) : 1;

    logic [NUM_ALU-1:0]                     alu_valid;
    issue_pkg::rs_entry [NUM_ALU-1:0]       alu_entry;
    logic [NUM_ALU-1:0][1:0]                alu_in_rf;
    issue_pkg::data_word [NUM_ALU-1:0][1:0] alu_captured;

    logic [NUM_MULT-1:0]                     mult_valid;
    issue_pkg::rs_entry [NUM_MULT-1:0]       mult_entry;
    logic [NUM_MULT-1:0][UNIT_BITS-1:0]      mult_unit;
    logic [NUM_MULT-1:0][1:0]                mult_in_rf;
    issue_pkg::data_word [NUM_MULT-1:0][1:0] mult_captured;

    // Selection side only knows which entries go where
    modport producer (
        input  clock,
        output alu_valid, alu_entry, mult_valid, mult_entry, mult_unit
    );

    modport buffer (
        output alu_valid, alu_entry, alu_in_rf, alu_captured,
        output mult_valid, mult_entry, mult_unit, mult_in_rf, mult_captured
    );

    modport consumer (
        input clock,
        input alu_valid, alu_entry, alu_in_rf, alu_captured,
        input mult_valid, mult_entry, mult_unit, mult_in_rf, mult_captured
    );

endinterface

// File: design/issue_stage.sv
`timescale 1ns/100ps

module issue_stage #(
    parameter int RS_SIZE = 8,
    parameter int NUM_ALU = 2,
    parameter int NUM_MULT = 2,
    parameter int CDB_PORTS = 2
) (
    input  logic                                   clock,
    input  logic                                   reset,
    input  issue_pkg::rs_entry [RS_SIZE-1:0]       rs_entries,
    input  logic [issue_pkg::NUM_PHYS_REGS-1:0]    complete_list,
    input  issue_pkg::cdb_broadcast [CDB_PORTS-1:0] cdb,
    input  logic [NUM_MULT-1:0]                    mult_free,
    input  logic [NUM_MULT-1:0]                    mult_cdb_req,
    output issue_pkg::phys_reg [NUM_ALU-1:0][1:0]  alu_read_idx,
    output issue_pkg::phys_reg [NUM_MULT-1:0][1:0] mult_read_idx,
    input  issue_pkg::data_word [NUM_ALU-1:0][1:0]  alu_read_data,
    input  issue_pkg::data_word [NUM_MULT-1:0][1:0] mult_read_data,
    output logic [RS_SIZE-1:0]                     rs_issuing,
    output logic [NUM_MULT-1:0]                    mult_cdb_gnt,
    output issue_pkg::alu_packet [NUM_ALU-1:0]     alu_packets,
    output issue_pkg::mult_packet [NUM_MULT-1:0]   mult_packets
);

    // Selection cycle output and the buffered copy one cycle later
    issue_slot_if #(.NUM_ALU(NUM_ALU), .NUM_MULT(NUM_MULT)) sel_slots (.clock(clock));
    issue_slot_if #(.NUM_ALU(NUM_ALU), .NUM_MULT(NUM_MULT)) held_slots (.clock(clock));

    ready_select #(
        .RS_SIZE(RS_SIZE),
        .NUM_ALU(NUM_ALU),
        .NUM_MULT(NUM_MULT),
        .CDB_PORTS(CDB_PORTS)
    ) u_ready_select (
        .rs_entries(rs_entries),
        .mult_free(mult_free),
        .mult_cdb_req(mult_cdb_req),
        .sel_slots(sel_slots.producer),
        .rs_issuing(rs_issuing),
        .mult_cdb_gnt(mult_cdb_gnt),
        .alu_read_idx(alu_read_idx),
        .mult_read_idx(mult_read_idx)
    );

    issue_register #(
        .NUM_ALU(NUM_ALU),
        .NUM_MULT(NUM_MULT),
        .CDB_PORTS(CDB_PORTS)
    ) u_issue_register (
        .clock(clock),
        .reset(reset),
        .complete_list(complete_list),
        .cdb(cdb),
        .sel_slots(sel_slots.consumer),
        .held_slots(held_slots.buffer)
    );

    operand_route #(
        .NUM_ALU(NUM_ALU),
        .NUM_MULT(NUM_MULT)
    ) u_operand_route (
        .held_slots(held_slots.consumer),
        .alu_read_data(alu_read_data),
        .mult_read_data(mult_read_data),
        .alu_packets(alu_packets),
        .mult_packets(mult_packets)
    );

endmodule

// File: design/operand_route.sv
`timescale 1ns/100ps

module operand_route #(
    parameter int NUM_ALU = 2,
    parameter int NUM_MULT = 2
) (
    issue_slot_if.consumer                          held_slots,
    input  issue_pkg::data_word [NUM_ALU-1:0][1:0]  alu_read_data,
    input  issue_pkg::data_word [NUM_MULT-1:0][1:0] mult_read_data,
    output issue_pkg::alu_packet [NUM_ALU-1:0]      alu_packets,
    output issue_pkg::mult_packet [NUM_MULT-1:0]    mult_packets
);
    issue_pkg::data_word [NUM_ALU-1:0][1:0]  alu_operands;
    issue_pkg::data_word [NUM_MULT-1:0][1:0] mult_operands;
    logic [NUM_MULT-1:0]                     mult_packet_valid;

    // Register file value unless the source was caught on the cdb
    function automatic issue_pkg::data_word pick_operand(
        logic                in_rf,
        issue_pkg::data_word read_data,
        issue_pkg::data_word captured
    );
        return in_rf ? read_data : captured;
    endfunction

    always_comb begin
        for (int k = 0; k < NUM_ALU; k++) begin
            for (int s = 0; s < 2; s++) begin
                alu_operands[k][s] = pick_operand(held_slots.alu_in_rf[k][s],
                                                  alu_read_data[k][s],
                                                  held_slots.alu_captured[k][s]);
            end
        end
        for (int k = 0; k < NUM_MULT; k++) begin
            for (int s = 0; s < 2; s++) begin
                mult_operands[k][s] = pick_operand(held_slots.mult_in_rf[k][s],
                                                   mult_read_data[k][s],
                                                   held_slots.mult_captured[k][s]);
            end
        end
    end

    always_comb begin
        for (int k = 0; k < NUM_ALU; k++) begin
            alu_packets[k].valid = held_slots.alu_valid[k];
            alu_packets[k].dest = held_slots.alu_entry[k].dest;
            alu_packets[k].op = isa_pkg::alu_op'(held_slots.alu_entry[k].inst.r.funct3);
            alu_packets[k].operand_a = alu_operands[k][0];
            if (held_slots.alu_entry[k].opb == isa_pkg::OPB_IMM) begin
                alu_packets[k].operand_b = {{20{held_slots.alu_entry[k].inst.i.imm[11]}},
                                            held_slots.alu_entry[k].inst.i.imm};
            end else begin
                alu_packets[k].operand_b = alu_operands[k][1];
            end
        end
    end

    // Slot order is pick order, packet position is the target unit
    always_comb begin
        mult_packets = '0;
        for (int k = 0; k < NUM_MULT; k++) begin
            if (held_slots.mult_valid[k]) begin
                mult_packets[held_slots.mult_unit[k]] = '{
                    valid:     1'b1,
                    dest:      held_slots.mult_entry[k].dest,
                    mult_func: held_slots.mult_entry[k].inst.r.funct3,
                    operand_a: mult_operands[k][0],
                    operand_b: mult_operands[k][1]
                };
            end
        end
    end

    for (genvar u = 0; u < NUM_MULT; u++) begin : g_mult_valid
        assign mult_packet_valid[u] = mult_packets[u].valid;
    end

    // Every held multiply lands on its own unit, nothing else shows up
    assert property (@(posedge held_slots.clock)
        $countones(mult_packet_valid) == $countones(held_slots.mult_valid));

endmodule

// File: design/ready_select.sv
`timescale 1ns/100ps

module ready_select #(
    parameter int RS_SIZE = 8,
    parameter int NUM_ALU = 2,
    parameter int NUM_MULT = 2,
    parameter int CDB_PORTS = 2
) (
    input  issue_pkg::rs_entry [RS_SIZE-1:0]       rs_entries,
    input  logic [NUM_MULT-1:0]                    mult_free,
    input  logic [NUM_MULT-1:0]                    mult_cdb_req,
    issue_slot_if.producer                         sel_slots,
    output logic [RS_SIZE-1:0]                     rs_issuing,
    output logic [NUM_MULT-1:0]                    mult_cdb_gnt,
    output issue_pkg::phys_reg [NUM_ALU-1:0][1:0]  alu_read_idx,
    output issue_pkg::phys_reg [NUM_MULT-1:0][1:0] mult_read_idx
);
    localparam int UNIT_BITS = (NUM_MULT > 1) ? $clog2(NUM_MULT) : 1;
    localparam int IDX_BITS = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    logic [RS_SIZE-1:0]  alu_ready;
    logic [RS_SIZE-1:0]  mult_ready;
    logic [IDX_BITS-1:0] alu_pick [NUM_ALU];
    logic [IDX_BITS-1:0] mult_pick [NUM_MULT];

    for (genvar e = 0; e < RS_SIZE; e++) begin : g_ready
        logic both_ready;

        assign both_ready = rs_entries[e].valid && rs_entries[e].source1_ready
                            && rs_entries[e].source2_ready;
        assign alu_ready[e] = both_ready && (rs_entries[e].kind == isa_pkg::FU_ALU);
        assign mult_ready[e] = both_ready && (rs_entries[e].kind == isa_pkg::FU_MULT);
    end

    always_comb begin
        logic [UNIT_BITS-1:0] free_units [NUM_MULT];
        int free_n;
        int ports;
        int alu_n;
        int mult_n;

        free_n = 0;
        ports = 0;
        alu_n = 0;
        mult_n = 0;
        mult_cdb_gnt = '0;
        rs_issuing = '0;
        sel_slots.alu_valid = '0;
        sel_slots.alu_entry = '0;
        sel_slots.mult_valid = '0;
        sel_slots.mult_entry = '0;
        sel_slots.mult_unit = '0;
        for (int k = 0; k < NUM_ALU; k++) begin
            alu_pick[k] = '0;
        end
        for (int u = 0; u < NUM_MULT; u++) begin
            mult_pick[u] = '0;
            free_units[u] = '0;
        end

        // Multipliers finishing next cycle claim completion ports first
        for (int u = 0; u < NUM_MULT; u++) begin
            if (mult_cdb_req[u] && ports < CDB_PORTS) begin
                mult_cdb_gnt[u] = 1'b1;
                ports++;
            end
        end

        // Free units in index order
        for (int u = 0; u < NUM_MULT; u++) begin
            if (mult_free[u]) begin
                free_units[free_n] = UNIT_BITS'(u);
                free_n++;
            end
        end

        // Lowest entries first, an ALU pick also needs a port left
        for (int e = 0; e < RS_SIZE; e++) begin
            if (alu_ready[e] && alu_n < NUM_ALU && ports < CDB_PORTS) begin
                sel_slots.alu_valid[alu_n] = 1'b1;
                sel_slots.alu_entry[alu_n] = rs_entries[e];
                alu_pick[alu_n] = IDX_BITS'(e);
                rs_issuing[e] = 1'b1;
                alu_n++;
                ports++;
            end
            if (mult_ready[e] && mult_n < free_n) begin
                sel_slots.mult_valid[mult_n] = 1'b1;
                sel_slots.mult_entry[mult_n] = rs_entries[e];
                sel_slots.mult_unit[mult_n] = free_units[mult_n];
                mult_pick[mult_n] = IDX_BITS'(e);
                rs_issuing[e] = 1'b1;
                mult_n++;
            end
        end
    end

    // Empty slots carry a zero entry, so their indices read register 0
    for (genvar k = 0; k < NUM_ALU; k++) begin : g_alu_idx
        assign alu_read_idx[k][0] = sel_slots.alu_entry[k].source1;
        assign alu_read_idx[k][1] = sel_slots.alu_entry[k].source2;

        // Slot holds the issued station entry, a valid ready ALU entry
        assert property (@(posedge sel_slots.clock)
            sel_slots.alu_valid[k] |-> rs_issuing[alu_pick[k]]
                && sel_slots.alu_entry[k] == rs_entries[alu_pick[k]]
                && sel_slots.alu_entry[k].valid
                && sel_slots.alu_entry[k].source1_ready
                && sel_slots.alu_entry[k].source2_ready
                && sel_slots.alu_entry[k].kind == isa_pkg::FU_ALU);
    end

    for (genvar k = 0; k < NUM_MULT; k++) begin : g_mult_idx
        assign mult_read_idx[k][0] = sel_slots.mult_entry[k].source1;
        assign mult_read_idx[k][1] = sel_slots.mult_entry[k].source2;

        // Chosen entry issued and its unit is free
        assert property (@(posedge sel_slots.clock)
            sel_slots.mult_valid[k] |-> rs_issuing[mult_pick[k]]
                && sel_slots.mult_entry[k] == rs_entries[mult_pick[k]]
                && sel_slots.mult_entry[k].valid
                && sel_slots.mult_entry[k].source1_ready
                && sel_slots.mult_entry[k].source2_ready
                && sel_slots.mult_entry[k].kind == isa_pkg::FU_MULT
                && mult_free[sel_slots.mult_unit[k]]);
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with assertions enabled, then run; the exit status tells pass or fail
verilator --binary --timing --assert --top-module tb_issue_stage -f sim.f \
    -o tb_issue_stage \
    && ./obj_dir/tb_issue_stage \
    || exit 1

// File: sim.f
+incdir+tests
design/isa_pkg.sv
design/issue_pkg.sv
design/issue_slot_if.sv
design/ready_select.sv
design/issue_register.sv
design/operand_route.sv
design/issue_stage.sv
tests/tb_issue_stage.sv

// File: tests/issue_vectors.svh
`ifndef ISSUE_VECTORS_SVH
`define ISSUE_VECTORS_SVH

// Registers 0 to 20 are complete, 40 and 41 are still in flight
localparam logic [63:0] COMPLETE = 64'h0000_0000_001f_ffff;
localparam int NO = -1;
localparam isa_pkg::fu_kind ALU = isa_pkg::FU_ALU;
localparam isa_pkg::fu_kind MUL = isa_pkg::FU_MULT;
localparam isa_pkg::opb_source REG = isa_pkg::OPB_REG;
localparam isa_pkg::opb_source IMM = isa_pkg::OPB_IMM;

task automatic load_vectors;
    // Pool: valid, kind, source1, ready1, source2, ready2, dest, opb, funct3, imm
    add_entry(1, ALU,  3, 1,  4, 1, 33, REG, 3'd0, 12'h000);  // 0 add
    add_entry(1, ALU,  5, 1,  0, 1, 34, IMM, 3'd4, 12'hf9c);  // 1 xori with -100
    add_entry(1, ALU,  6, 1,  7, 1, 35, REG, 3'd3, 12'h000);  // 2 sltu
    add_entry(1, ALU, 40, 1,  8, 1, 36, REG, 3'd0, 12'h000);  // 3 add, source1 on cdb
    add_entry(1, MUL,  9, 1, 10, 1, 37, REG, 3'd0, 12'h000);  // 4 mul
    add_entry(1, MUL, 11, 1, 12, 1, 38, REG, 3'd1, 12'h000);  // 5 mulh
    add_entry(1, ALU, 13, 1, 41, 0, 39, REG, 3'd0, 12'h000);  // 6 source2 not ready
    add_entry(0, ALU, 14, 1, 15, 1, 42, REG, 3'd0, 12'h000);  // 7 invalid
    add_entry(1, ALU, 16, 1,  0, 1, 43, IMM, 3'd6, 12'h07f);  // 8 ori

    // Rows: pool index at station entries 0 to 3, cdb register and result,
    // mult_free, mult_cdb_req, expected rs_issuing and mult_cdb_gnt, then the
    // station entry expected next cycle in ALU slots 0, 1 and at multipliers 0, 1

    // Idle after reset
    add_row(NO, NO, NO, NO, NO, 32'h0, 2'b11, 2'b00, 8'h00, 2'b00, NO, NO, NO, NO);
    // Three ready ALU entries, the third waits
    add_row( 0,  1,  2, NO, NO, 32'h0, 2'b00, 2'b00, 8'h03, 2'b00,  0,  1, NO, NO);
    add_row( 2, NO, NO, NO, NO, 32'h0, 2'b00, 2'b00, 8'h01, 2'b00,  0, NO, NO, NO);
    // Source caught on the cdb
    add_row( 3, NO, NO, NO, 40, 32'hcafe0040, 2'b00, 2'b00, 8'h01, 2'b00, 0, NO, NO, NO);
    // No multiplier free, then only unit 1
    add_row( 4,  5, NO, NO, NO, 32'h0, 2'b00, 2'b00, 8'h00, 2'b00, NO, NO, NO, NO);
    add_row( 4,  5, NO, NO, NO, 32'h0, 2'b10, 2'b00, 8'h01, 2'b00, NO, NO, NO,  0);
    // Both multipliers finishing take every port
    add_row( 4,  0,  8, NO, NO, 32'h0, 2'b00, 2'b11, 8'h00, 2'b11, NO, NO, NO, NO);
    // One multiplier finishing leaves a port for one ALU entry
    add_row( 5,  0,  8, NO, NO, 32'h0, 2'b01, 2'b01, 8'h03, 2'b01,  1, NO,  0, NO);
    // Not ready and invalid entries stay put
    add_row( 8,  6,  7, NO, NO, 32'h0, 2'b00, 2'b00, 8'h01, 2'b00,  0, NO, NO, NO);
    add_row( 6,  7, NO, NO, NO, 32'h0, 2'b11, 2'b00, 8'h00, 2'b00, NO, NO, NO, NO);
    add_row(NO, NO, NO, NO, NO, 32'h0, 2'b11, 2'b00, 8'h00, 2'b00, NO, NO, NO, NO);
endtask

`endif

// File: tests/tb_issue_stage.sv
`timescale 1ns/100ps

module tb_issue_stage;

    localparam int RS_SIZE = 8;
    localparam int NUM_ALU = 2;
    localparam int NUM_MULT = 2;
    localparam int CDB_PORTS = 2;
    localparam int IDLE_LIMIT = 20;

    // Pool index 31 and position 7 mean none
    typedef struct packed {
        logic [3:0][4:0]     slot;
        logic                cdb_valid;
        issue_pkg::phys_reg  cdb_reg;
        issue_pkg::data_word cdb_result;
        logic [1:0]          free;
        logic [1:0]          req;
        logic [7:0]          exp_issuing;
        logic [1:0]          exp_gnt;
        logic [1:0][2:0]     exp_alu;
        logic [1:0][2:0]     exp_mult;
    } vector_row;

    logic clock;
    logic reset;
    issue_pkg::rs_entry [RS_SIZE-1:0]        rs_entries;
    logic [issue_pkg::NUM_PHYS_REGS-1:0]     complete_list;
    issue_pkg::cdb_broadcast [CDB_PORTS-1:0] cdb;
    logic [NUM_MULT-1:0]                     mult_free;
    logic [NUM_MULT-1:0]                     mult_cdb_req;
    issue_pkg::phys_reg [NUM_ALU-1:0][1:0]   alu_read_idx;
    issue_pkg::phys_reg [NUM_MULT-1:0][1:0]  mult_read_idx;
    issue_pkg::data_word [NUM_ALU-1:0][1:0]  alu_read_data;
    issue_pkg::data_word [NUM_MULT-1:0][1:0] mult_read_data;
    logic [RS_SIZE-1:0]                      rs_issuing;
    logic [NUM_MULT-1:0]                     mult_cdb_gnt;
    issue_pkg::alu_packet [NUM_ALU-1:0]      alu_packets;
    issue_pkg::mult_packet [NUM_MULT-1:0]    mult_packets;

    integer seed = 19;
    issue_pkg::rs_entry pool[$];
    vector_row rows[$];
    issue_pkg::phys_reg [NUM_ALU-1:0][1:0]  alu_idx_q;
    issue_pkg::phys_reg [NUM_MULT-1:0][1:0] mult_idx_q;

    `include "issue_vectors.svh"

    issue_stage #(
        .RS_SIZE(RS_SIZE),
        .NUM_ALU(NUM_ALU),
        .NUM_MULT(NUM_MULT),
        .CDB_PORTS(CDB_PORTS)
    ) uut (
        .clock(clock),
        .reset(reset),
        .rs_entries(rs_entries),
        .complete_list(complete_list),
        .cdb(cdb),
        .mult_free(mult_free),
        .mult_cdb_req(mult_cdb_req),
        .alu_read_idx(alu_read_idx),
        .mult_read_idx(mult_read_idx),
        .alu_read_data(alu_read_data),
        .mult_read_data(mult_read_data),
        .rs_issuing(rs_issuing),
        .mult_cdb_gnt(mult_cdb_gnt),
        .alu_packets(alu_packets),
        .mult_packets(mult_packets)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Register file answers each index one cycle later with 1000 plus the index
    initial begin
        alu_read_data = '0;
        mult_read_data = '0;
        forever begin
            @(posedge clock);
            alu_idx_q = alu_read_idx;
            mult_idx_q = mult_read_idx;
            #10;
            for (int k = 0; k < NUM_ALU; k++) begin
                for (int s = 0; s < 2; s++) begin
                    alu_read_data[k][s] = 32'(1000 + int'(alu_idx_q[k][s]));
                end
            end
            for (int k = 0; k < NUM_MULT; k++) begin
                for (int s = 0; s < 2; s++) begin
                    mult_read_data[k][s] = 32'(1000 + int'(mult_idx_q[k][s]));
                end
            end
        end
    end

    task automatic add_entry(input int valid, input isa_pkg::fu_kind kind,
                             input int source1, input int ready1,
                             input int source2, input int ready2, input int dest,
                             input isa_pkg::opb_source opb, input logic [2:0] funct3,
                             input logic [11:0] imm);
        issue_pkg::rs_entry e;

        // Fields the issue stage ignores get random bits
        e.inst.r.funct7 = 7'($random(seed));
        e.inst.r.rs2 = 5'($random(seed));
        e.inst.r.rs1 = 5'($random(seed));
        e.inst.r.rd = 5'($random(seed));
        e.inst.r.opcode = 7'($random(seed));
        e.inst.r.funct3 = funct3;
        if (opb == isa_pkg::OPB_IMM) begin
            e.inst.i.imm = imm;
        end
        e.valid = valid != 0;
        e.source1 = issue_pkg::phys_reg'(source1);
        e.source1_ready = ready1 != 0;
        e.source2 = issue_pkg::phys_reg'(source2);
        e.source2_ready = ready2 != 0;
        e.dest = issue_pkg::phys_reg'(dest);
        e.kind = kind;
        e.opb = opb;
        pool.push_back(e);
    endtask

    function automatic logic [4:0] slot_code(input int s);
        return (s < 0) ? 5'd31 : 5'(s);
    endfunction

    function automatic logic [2:0] position_code(input int p);
        return (p < 0) ? 3'd7 : 3'(p);
    endfunction

    task automatic add_row(input int s0, input int s1, input int s2, input int s3,
                           input int cdb_reg, input logic [31:0] cdb_result,
                           input logic [1:0] free, input logic [1:0] req,
                           input logic [7:0] issuing, input logic [1:0] gnt,
                           input int alu0, input int alu1, input int mult0, input int mult1);
        vector_row r;

        r.slot[0] = slot_code(s0);
        r.slot[1] = slot_code(s1);
        r.slot[2] = slot_code(s2);
        r.slot[3] = slot_code(s3);
        r.cdb_valid = cdb_reg >= 0;
        r.cdb_reg = (cdb_reg >= 0) ? issue_pkg::phys_reg'(cdb_reg) : '0;
        r.cdb_result = cdb_result;
        r.free = free;
        r.req = req;
        r.exp_issuing = issuing;
        r.exp_gnt = gnt;
        r.exp_alu[0] = position_code(alu0);
        r.exp_alu[1] = position_code(alu1);
        r.exp_mult[0] = position_code(mult0);
        r.exp_mult[1] = position_code(mult1);
        rows.push_back(r);
    endtask

    task automatic apply_row(input vector_row r);
        rs_entries = '0;
        for (int e = 0; e < 4; e++) begin
            if (r.slot[e] != 5'd31) begin
                rs_entries[e] = pool[r.slot[e]];
            end
        end
        complete_list = COMPLETE;
        cdb = '0;
        cdb[0].valid = r.cdb_valid;
        cdb[0].completing_reg = r.cdb_reg;
        cdb[0].result = r.cdb_result;
        mult_free = r.free;
        mult_cdb_req = r.req;
    endtask

    task automatic check_value(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    // Complete sources come from the register file, others from the cdb
    function automatic issue_pkg::data_word expected_operand(input vector_row r,
                                                             input issue_pkg::phys_reg src);
        if (COMPLETE[src]) begin
            return 32'(1000 + int'(src));
        end else if (r.cdb_valid && r.cdb_reg == src) begin
            return r.cdb_result;
        end
        return '0;
    endfunction

    function automatic issue_pkg::alu_packet expected_alu(input vector_row r,
                                                          input issue_pkg::rs_entry e);
        issue_pkg::alu_packet p;
        logic signed [31:0] wide_imm;

        wide_imm = $signed(e.inst.i.imm);
        p.valid = 1'b1;
        p.dest = e.dest;
        p.op = isa_pkg::alu_op'(e.inst.r.funct3);
        p.operand_a = expected_operand(r, e.source1);
        if (e.opb == isa_pkg::OPB_IMM) begin
            p.operand_b = wide_imm;
        end else begin
            p.operand_b = expected_operand(r, e.source2);
        end
        return p;
    endfunction

    function automatic issue_pkg::mult_packet expected_mult(input vector_row r,
                                                            input issue_pkg::rs_entry e);
        issue_pkg::mult_packet p;

        p.valid = 1'b1;
        p.dest = e.dest;
        p.mult_func = e.inst.r.funct3;
        p.operand_a = expected_operand(r, e.source1);
        p.operand_b = expected_operand(r, e.source2);
        return p;
    endfunction

    task automatic check_packets(input vector_row r,
                                 input issue_pkg::rs_entry [RS_SIZE-1:0] entries);
        for (int k = 0; k < NUM_ALU; k++) begin
            if (r.exp_alu[k] == 3'd7) begin
                check_value($sformatf("alu_packets[%0d].valid", k),
                            96'(alu_packets[k].valid), '0);
            end else begin
                check_value($sformatf("alu_packets[%0d]", k), 96'(alu_packets[k]),
                            96'(expected_alu(r, entries[r.exp_alu[k]])));
            end
        end
        for (int u = 0; u < NUM_MULT; u++) begin
            if (r.exp_mult[u] == 3'd7) begin
                check_value($sformatf("mult_packets[%0d].valid", u),
                            96'(mult_packets[u].valid), '0);
            end else begin
                check_value($sformatf("mult_packets[%0d]", u), 96'(mult_packets[u]),
                            96'(expected_mult(r, entries[r.exp_mult[u]])));
            end
        end
    endtask

    function automatic logic outputs_busy();
        logic busy;

        busy = (rs_issuing != '0) || (mult_cdb_gnt != '0);
        for (int k = 0; k < NUM_ALU; k++) begin
            busy |= alu_packets[k].valid;
        end
        for (int u = 0; u < NUM_MULT; u++) begin
            busy |= mult_packets[u].valid;
        end
        return busy;
    endfunction

    task automatic wait_idle;
        int cycles;

        cycles = 0;
        while (outputs_busy()) begin
            if (cycles >= IDLE_LIMIT) begin
                $display("Timeout: packet valids or issue outputs stay high after reset");
                $display("ERRORS FOUND");
                $fatal(1);
            end else begin
                @(posedge clock);
                cycles++;
            end
        end
    endtask

    initial begin
        vector_row prev;
        issue_pkg::rs_entry [RS_SIZE-1:0] prev_entries;

        reset = 1'b1;
        rs_entries = '0;
        complete_list = '0;
        cdb = '0;
        mult_free = '0;
        mult_cdb_req = '0;
        prev = '0;
        prev_entries = '0;
        load_vectors();
        repeat (16) @(posedge clock);
        #10;
        reset = 1'b0;
        wait_idle();

        // Packets of a row show up while the next row is applied
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clock);
            #10;
            apply_row(rows[i]);
            #50;
            check_value("rs_issuing", 96'(rs_issuing), 96'(rows[i].exp_issuing));
            check_value("mult_cdb_gnt", 96'(mult_cdb_gnt), 96'(rows[i].exp_gnt));
            if (i > 0) begin
                check_packets(prev, prev_entries);
            end
            prev = rows[i];
            prev_entries = rs_entries;
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule
